/* hw/mmio_test_pkg.sv */
// Shared widths, identity constants and the read index enum
// of the MMIO test target
`default_nettype none

package mmio_test_pkg;

    // ======================================================================
    // Bus widths
    // ======================================================================

    // The narrow port moves 64-bit words addressed by a 12-bit word index
    localparam int mmio64_data_w = 64;
    localparam int mmio64_addr_w = 12;

    // The wide port moves 512-bit lines addressed by a 6-bit line index
    localparam int mmio512_data_w = 512;
    localparam int mmio512_addr_w = 6;

    // ======================================================================
    // Stall pattern
    // ======================================================================

    // One zero rotates through this many positions
    localparam int stall_period = 16;
    // The wide port watches the pattern halfway round from the narrow port
    localparam int stall_offset_512 = 8;

    // ======================================================================
    // Identity
    // ======================================================================

    localparam logic [127:0] afu_id = 128'h9f3c_51e2_0b7a_4d68_a1c4_7e25_d0b3_86f1;

    // Clock frequency reported in the status word
    localparam logic [15:0] pclk_freq_mhz = 16'd250;

    // Interface type code for Avalon
    localparam logic [3:0] if_type_avalon = 4'h0;

    // Feature header of a single-entry list
    // Type field 1 marks an AFU and bit 40 marks the end of the list
    localparam logic [63:0] dfh_value = {4'h1, 19'h0, 1'b1, 40'h0};

    // Word indices that the read side decodes
    // The header group occupies 0x00x and the wide data occupies 0x040 to 0x047
    typedef enum logic [11:0] {
        csr_dfh             = 12'h000,
        csr_afu_id_l        = 12'h001,
        csr_afu_id_h        = 12'h002,
        csr_status          = 12'h010,
        csr_wr64_data       = 12'h020,
        csr_wr64_addr       = 12'h030,
        csr_wr64_mask       = 12'h031,
        csr_wr512_data_base = 12'h040,
        csr_wr512_addr      = 12'h050,
        csr_wr512_mask      = 12'h051
    } t_csr_idx;

endpackage

`default_nettype wire

/* hw/wait_pattern_gen.sv */
// Rotating stall pattern that drives waitrequest on both slave ports
`timescale 1ns/1ps
`default_nettype none

module wait_pattern_gen (
    input  logic clk,
    input  logic reset_n,
    output logic mmio64_waitrequest,
    output logic mmio512_waitrequest
);

    // A single zero circulates through the pattern
    // Each port is ready only while the zero sits on its tap
    logic [mmio_test_pkg::stall_period-1:0] stall_vec;

    // ======================================================================
    // Pattern register
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            // The zero starts on the narrow tap
            // so the narrow port is ready right after reset
            stall_vec <= {{(mmio_test_pkg::stall_period - 1){1'b1}}, 1'b0};
        end
        else
        begin
            // Rotate left by one position every cycle
            stall_vec <= {stall_vec[mmio_test_pkg::stall_period-2:0],
                          stall_vec[mmio_test_pkg::stall_period-1]};
        end
    end

    // Narrow port taps position 0
    assign mmio64_waitrequest = stall_vec[0];

    // Wide port taps a later position and so sees the zero 8 cycles after
    assign mmio512_waitrequest = stall_vec[mmio_test_pkg::stall_offset_512];

    // The pattern never loses or gains a zero
    // Otherwise a port could stall forever or accept twice per period
    a_single_zero: assert property (
        @(posedge clk) disable iff (!reset_n)
        $onehot(~stall_vec)
    );

endmodule

`default_nettype wire

/* hw/write_capture.sv */
// Record of the data, address and byte mask of the last accepted write
// on one slave port, for any data and address width
`timescale 1ns/1ps
`default_nettype none

module write_capture #(
    parameter int data_w = mmio_test_pkg::mmio64_data_w,
    parameter int addr_w = mmio_test_pkg::mmio64_addr_w
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                write,
    input  logic                waitrequest,
    input  logic [addr_w-1:0]   address,
    input  logic [data_w-1:0]   writedata,
    input  logic [data_w/8-1:0] byteenable,
    output logic [data_w-1:0]   last_data,
    output logic [addr_w-1:0]   last_addr,
    output logic [data_w/8-1:0] last_mask
);

    // A write is taken at the edge where write is high and waitrequest is low
    logic write_accept;

    assign write_accept = write && !waitrequest;

    // ======================================================================
    // Capture registers
    // ======================================================================

    // Every accepted write replaces the previous record
    // Any address may be written and none of them changes behaviour
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            // The read side shows zero until the first write lands
            last_data <= '0;
            last_addr <= '0;
            last_mask <= '0;
        end
        else if (write_accept)
        begin
            last_data <= writedata;
            last_addr <= address;
            // The byte mask tells the access size seen on the bus
            last_mask <= byteenable;
        end
    end

    // The host must present a known address and mask with every write
    // An unknown here would end up in a record that the host reads back
    a_write_fields_known: assert property (
        @(posedge clk) disable iff (!reset_n)
        write_accept |-> !$isunknown({address, byteenable})
    );

endmodule

`default_nettype wire

/* hw/csr_read_mux.sv */
// Two-stage read pipeline for the 64-bit port that reduces the header group
// and the wide write record, then selects the returned word
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
    input  logic                                         clk,
    input  logic                                         reset_n,
    input  logic                                         read,
    input  logic                                         waitrequest,
    input  logic [mmio_test_pkg::mmio64_addr_w-1:0]      address,
    input  logic [mmio_test_pkg::mmio64_data_w-1:0]      wr64_data,
    input  logic [mmio_test_pkg::mmio64_addr_w-1:0]      wr64_addr,
    input  logic [mmio_test_pkg::mmio64_data_w/8-1:0]    wr64_mask,
    input  logic [mmio_test_pkg::mmio512_data_w-1:0]     wr512_data,
    input  logic [mmio_test_pkg::mmio512_addr_w-1:0]     wr512_addr,
    input  logic [mmio_test_pkg::mmio512_data_w/8-1:0]   wr512_mask,
    output logic [mmio_test_pkg::mmio64_data_w-1:0]      readdata,
    output logic                                         readdatavalid
);

    // Read accept strobe on the narrow port
    logic read_accept;

    // Stage one state
    logic                                    read_req_q;
    mmio_test_pkg::t_csr_idx                 read_idx_q;
    logic [mmio_test_pkg::mmio64_data_w-1:0] hdr_q;
    logic [mmio_test_pkg::mmio64_data_w-1:0] slice_q;

    // Stage two result
    logic [mmio_test_pkg::mmio64_data_w-1:0] next_word;

    assign read_accept = read && !waitrequest;

    // ======================================================================
    // Stage one
    // ======================================================================

    // Accept strobe for the cycle after the request
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            read_req_q <= 1'b0;
        end
        else
        begin
            read_req_q <= read_accept;
        end
    end

    // The index is kept for the second cycle where the group is chosen
    always_ff @(posedge clk)
    begin
        read_idx_q <= mmio_test_pkg::t_csr_idx'(address);
    end

    // Header and identity words share the 0x00x group
    // and are reduced by the low nibble of the index
    always_ff @(posedge clk)
    begin
        case (address[3:0])
            4'h0: hdr_q <= mmio_test_pkg::dfh_value;
            4'h1: hdr_q <= mmio_test_pkg::afu_id[63:0];
            4'h2: hdr_q <= mmio_test_pkg::afu_id[127:64];
            default: hdr_q <= '0;
        endcase
    end

    // Pick one 64-bit slice of the last wide write
    // Index bits 2:0 select the slice and slice 0 holds data bits 63:0
    always_ff @(posedge clk)
    begin
        slice_q <= wr512_data[{address[2:0], 6'b0} +: mmio_test_pkg::mmio64_data_w];
    end

    // ======================================================================
    // Stage two
    // ======================================================================

    // Choose among the already reduced groups and the single registers
    always_comb
    begin
        next_word = '0;
        if (read_idx_q[11:4] == 8'(mmio_test_pkg::csr_dfh >> 4))
        begin
            next_word = hdr_q;
        end
        else if (read_idx_q[11:3] == 9'(mmio_test_pkg::csr_wr512_data_base >> 3))
        begin
            // Only 0x040 to 0x047 map onto the wide data, so 0x048 falls through
            next_word = slice_q;
        end
        else
        begin
            case (read_idx_q)
                // Status word with the clock frequency and the interface type
                mmio_test_pkg::csr_status:
                    next_word = {32'h0, mmio_test_pkg::pclk_freq_mhz, 12'h0,
                                 mmio_test_pkg::if_type_avalon};
                mmio_test_pkg::csr_wr64_data:  next_word = wr64_data;
                mmio_test_pkg::csr_wr64_addr:  next_word = 64'(wr64_addr);
                mmio_test_pkg::csr_wr64_mask:  next_word = 64'(wr64_mask);
                mmio_test_pkg::csr_wr512_addr: next_word = 64'(wr512_addr);
                mmio_test_pkg::csr_wr512_mask: next_word = 64'(wr512_mask);
                // Unmapped indices read as zero
                default:                       next_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            readdatavalid <= 1'b0;
        end
        else
        begin
            readdatavalid <= read_req_q;
        end
    end

    // Stage two register for the returned word
    always_ff @(posedge clk)
    begin
        readdata <= next_word;
    end

    // Each accepted read yields a valid pulse after two edges
    a_read_latency: assert property (
        @(posedge clk) disable iff (!reset_n)
        read_accept |-> ##2 readdatavalid
    );

    // No valid pulse appears without a read two edges before it
    a_no_spurious_valid: assert property (
        @(posedge clk) disable iff (!reset_n)
        readdatavalid |-> $past(read_accept, 2)
    );

endmodule

`default_nettype wire

/* hw/mmio_test_target.sv */
// Top level of the MMIO test target with the stall generator, the two
// write capture blocks and the read pipeline
`timescale 1ns/1ps
`default_nettype none

module mmio_test_target (
    input  logic                                        clk,
    input  logic                                        reset_n,

    // 64-bit read and write slave port
    input  logic                                        mmio64_read,
    input  logic                                        mmio64_write,
    input  logic [mmio_test_pkg::mmio64_addr_w-1:0]     mmio64_address,
    input  logic [mmio_test_pkg::mmio64_data_w-1:0]     mmio64_writedata,
    input  logic [mmio_test_pkg::mmio64_data_w/8-1:0]   mmio64_byteenable,
    output logic                                        mmio64_waitrequest,
    output logic [mmio_test_pkg::mmio64_data_w-1:0]     mmio64_readdata,
    output logic                                        mmio64_readdatavalid,

    // 512-bit write only slave port
    input  logic                                        mmio512_write,
    input  logic [mmio_test_pkg::mmio512_addr_w-1:0]    mmio512_address,
    input  logic [mmio_test_pkg::mmio512_data_w-1:0]    mmio512_writedata,
    input  logic [mmio_test_pkg::mmio512_data_w/8-1:0]  mmio512_byteenable,
    output logic                                        mmio512_waitrequest
);

    // Record of the last narrow write
    logic [mmio_test_pkg::mmio64_data_w-1:0]    wr64_data;
    logic [mmio_test_pkg::mmio64_addr_w-1:0]    wr64_addr;
    logic [mmio_test_pkg::mmio64_data_w/8-1:0]  wr64_mask;

    // Record of the last wide write
    logic [mmio_test_pkg::mmio512_data_w-1:0]   wr512_data;
    logic [mmio_test_pkg::mmio512_addr_w-1:0]   wr512_addr;
    logic [mmio_test_pkg::mmio512_data_w/8-1:0] wr512_mask;

    // ======================================================================
    // Back-pressure
    // ======================================================================

    // Both waitrequests come from one rotating pattern
    wait_pattern_gen stall_gen (
        .clk                 (clk),
        .reset_n             (reset_n),
        .mmio64_waitrequest  (mmio64_waitrequest),
        .mmio512_waitrequest (mmio512_waitrequest)
    );

    // ======================================================================
    // Write capture
    // ======================================================================

    write_capture #(
        .data_w (mmio_test_pkg::mmio64_data_w),
        .addr_w (mmio_test_pkg::mmio64_addr_w)
    ) capture64 (
        .clk         (clk),
        .reset_n     (reset_n),
        .write       (mmio64_write),
        .waitrequest (mmio64_waitrequest),
        .address     (mmio64_address),
        .writedata   (mmio64_writedata),
        .byteenable  (mmio64_byteenable),
        .last_data   (wr64_data),
        .last_addr   (wr64_addr),
        .last_mask   (wr64_mask)
    );

    // The wide port has no read side, so its record is only visible
    // through the narrow port
    write_capture #(
        .data_w (mmio_test_pkg::mmio512_data_w),
        .addr_w (mmio_test_pkg::mmio512_addr_w)
    ) capture512 (
        .clk         (clk),
        .reset_n     (reset_n),
        .write       (mmio512_write),
        .waitrequest (mmio512_waitrequest),
        .address     (mmio512_address),
        .writedata   (mmio512_writedata),
        .byteenable  (mmio512_byteenable),
        .last_data   (wr512_data),
        .last_addr   (wr512_addr),
        .last_mask   (wr512_mask)
    );

    // ======================================================================
    // Read path
    // ======================================================================

    csr_read_mux read_mux (
        .clk           (clk),
        .reset_n       (reset_n),
        .read          (mmio64_read),
        .waitrequest   (mmio64_waitrequest),
        .address       (mmio64_address),
        .wr64_data     (wr64_data),
        .wr64_addr     (wr64_addr),
        .wr64_mask     (wr64_mask),
        .wr512_data    (wr512_data),
        .wr512_addr    (wr512_addr),
        .wr512_mask    (wr512_mask),
        .readdata      (mmio64_readdata),
        .readdatavalid (mmio64_readdatavalid)
    );

endmodule

`default_nettype wire

/* testbench/tb_mmio_test_target.sv */
// Testbench for the MMIO test target with host tasks for both ports, a model
// of the write records, and assertions on read data, read latency and stalls
`timescale 1ns/1ps
`default_nettype none

module tb_mmio_test_target;

    localparam int clk_period_ns = 4;
    localparam int reset_cycles = 5;
    // Identity 4, reset contents 13, narrow record 8, wide record 11,
    // unmapped 15 and held reads 4
    localparam int num_transactions = 55;
    // Each transaction waits at most one stall period and the margin is four times that
    localparam int watchdog_ns = num_transactions * 16 * clk_period_ns * 4;

    logic                                        clk;
    logic                                        reset_n;
    logic                                        mmio64_read;
    logic                                        mmio64_write;
    logic [mmio_test_pkg::mmio64_addr_w-1:0]     mmio64_address;
    logic [mmio_test_pkg::mmio64_data_w-1:0]     mmio64_writedata;
    logic [mmio_test_pkg::mmio64_data_w/8-1:0]   mmio64_byteenable;
    logic                                        mmio64_waitrequest;
    logic [mmio_test_pkg::mmio64_data_w-1:0]     mmio64_readdata;
    logic                                        mmio64_readdatavalid;
    logic                                        mmio512_write;
    logic [mmio_test_pkg::mmio512_addr_w-1:0]    mmio512_address;
    logic [mmio_test_pkg::mmio512_data_w-1:0]    mmio512_writedata;
    logic [mmio_test_pkg::mmio512_data_w/8-1:0]  mmio512_byteenable;
    logic                                        mmio512_waitrequest;

    // Model of the last accepted write on each port
    logic [63:0]  ref_wr64_data;
    logic [11:0]  ref_wr64_addr;
    logic [7:0]   ref_wr64_mask;
    logic [511:0] ref_wr512_data;
    logic [5:0]   ref_wr512_addr;
    logic [63:0]  ref_wr512_mask;

    // Expected words of accepted reads, oldest first
    logic [63:0] exp_q[$];
    // The queue head is copied mid-cycle so the checks sample a stable value
    logic [63:0] head_word;
    logic        head_known;

    mmio_test_target DUT (.*);

    // ======================================================================
    // Clock, watchdog and failure reporting
    // ======================================================================

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clk_period_ns / 2) clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
    endtask

    initial
    begin
        #(watchdog_ns);
        abort_run("Timeout: the run did not finish within the expected time");
    end

    // ======================================================================
    // Reference model
    // ======================================================================

    // Expected read word for an index, built from the register map rules
    function automatic logic [63:0] expected_word(input logic [11:0] addr);
        logic [63:0] word;
        int          k;
        word = '0;
        k = int'(addr) - int'(mmio_test_pkg::csr_wr512_data_base);
        case (addr)
            mmio_test_pkg::csr_dfh:        word = mmio_test_pkg::dfh_value;
            mmio_test_pkg::csr_afu_id_l:   word = mmio_test_pkg::afu_id[63:0];
            mmio_test_pkg::csr_afu_id_h:   word = mmio_test_pkg::afu_id[127:64];
            mmio_test_pkg::csr_wr64_data:  word = ref_wr64_data;
            mmio_test_pkg::csr_wr64_addr:  word[11:0] = ref_wr64_addr;
            mmio_test_pkg::csr_wr64_mask:  word[7:0] = ref_wr64_mask;
            mmio_test_pkg::csr_wr512_addr: word[5:0] = ref_wr512_addr;
            mmio_test_pkg::csr_wr512_mask: word = ref_wr512_mask;
            mmio_test_pkg::csr_status:
            begin
                // Frequency in the upper half of the low word, type in the low nibble
                word[31:16] = mmio_test_pkg::pclk_freq_mhz;
                word[3:0] = mmio_test_pkg::if_type_avalon;
            end
            default:
            begin
                // Eight consecutive indices show the eight slices of the wide line
                if (k >= 0 && k < 8)
                begin
                    word = ref_wr512_data[64*k +: 64];
                end
            end
        endcase
        return word;
    endfunction

    function automatic logic [511:0] random_line();
        logic [511:0] line;
        for (int i = 0; i < 16; i++)
        begin
            line[32*i +: 32] = $urandom;
        end
        return line;
    endfunction

    // ======================================================================
    // Host tasks
    // ======================================================================

    // All tasks start and end 1 ns after a rising edge
    task automatic write_narrow(input logic [11:0] addr, input logic [63:0] data,
                                input logic [7:0] mask);
        mmio64_write = 1'b1;
        mmio64_address = addr;
        mmio64_writedata = data;
        mmio64_byteenable = mask;
        while (mmio64_waitrequest)
        begin
            @(posedge clk);
            #1;
        end
        // Accepting edge
        @(posedge clk);
        ref_wr64_data = data;
        ref_wr64_addr = addr;
        ref_wr64_mask = mask;
        #1;
        mmio64_write = 1'b0;
    endtask

    task automatic write_wide(input logic [5:0] addr, input logic [511:0] data,
                              input logic [63:0] mask);
        mmio512_write = 1'b1;
        mmio512_address = addr;
        mmio512_writedata = data;
        mmio512_byteenable = mask;
        while (mmio512_waitrequest)
        begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        ref_wr512_data = data;
        ref_wr512_addr = addr;
        ref_wr512_mask = mask;
        #1;
        mmio512_write = 1'b0;
    endtask

    // Leaves read high so that a following call holds the bus back to back
    task automatic read_word(input logic [11:0] addr);
        mmio64_read = 1'b1;
        mmio64_address = addr;
        while (mmio64_waitrequest)
        begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        exp_q.push_back(expected_word(addr));
        #1;
    endtask

    task automatic read_once(input logic [11:0] addr);
        read_word(addr);
        mmio64_read = 1'b0;
    endtask

    // The head leaves the queue at the edge that ends its valid cycle
    always @(posedge clk)
    begin
        if (reset_n && mmio64_readdatavalid && exp_q.size() > 0)
        begin
            void'(exp_q.pop_front());
        end
    end

    always @(negedge clk)
    begin
        head_known = (exp_q.size() > 0);
        head_word = head_known ? exp_q[0] : '0;
    end

    // ======================================================================
    // Checks
    // ======================================================================

    a_read_data: assert property (
        @(posedge clk) disable iff (!reset_n)
        mmio64_readdatavalid && head_known |-> mmio64_readdata === head_word
    ) else abort_run($sformatf("Fail at %0t: mmio64_readdata expected %h actual %h",
                               $time, head_word, $sampled(mmio64_readdata)));

    a_valid_has_read: assert property (
        @(posedge clk) disable iff (!reset_n)
        mmio64_readdatavalid |-> head_known
    ) else abort_run("readdatavalid was high with no read outstanding");

    // Accepted read yields a pulse two edges later and a pulse needs such a read
    a_read_latency: assert property (
        @(posedge clk) disable iff (!reset_n)
        mmio64_read && !mmio64_waitrequest |-> ##2 mmio64_readdatavalid
    ) else abort_run("An accepted read got no readdatavalid two cycles later");

    a_valid_after_read: assert property (
        @(posedge clk) disable iff (!reset_n)
        mmio64_readdatavalid |-> $past(mmio64_read && !mmio64_waitrequest, 2)
    ) else abort_run("readdatavalid came without a read accepted two cycles before");

    a_narrow_period: assert property (
        @(posedge clk) disable iff (!reset_n)
        !mmio64_waitrequest |=> mmio64_waitrequest [*15] ##1 !mmio64_waitrequest
    ) else abort_run("The narrow waitrequest was not low once in every 16 cycles");

    a_wide_period: assert property (
        @(posedge clk) disable iff (!reset_n)
        !mmio512_waitrequest |=> mmio512_waitrequest [*15] ##1 !mmio512_waitrequest
    ) else abort_run("The wide waitrequest was not low once in every 16 cycles");

    a_wide_offset: assert property (
        @(posedge clk) disable iff (!reset_n)
        !mmio64_waitrequest |-> ##8 !mmio512_waitrequest
    ) else abort_run("The wide waitrequest was not low 8 cycles after the narrow one");

    a_ready_after_reset: assert property (
        @(posedge clk) $rose(reset_n) |-> !mmio64_waitrequest
    ) else abort_run("The narrow waitrequest was high in the first cycle after reset");

    // ======================================================================
    // Stimulus
    // ======================================================================

    initial
    begin : stimulus
        logic [11:0] addr;
        void'($urandom(92631));
        reset_n = 1'b0;
        mmio64_read = 1'b0;
        mmio64_write = 1'b0;
        mmio64_address = '0;
        mmio64_writedata = '0;
        mmio64_byteenable = '0;
        mmio512_write = 1'b0;
        mmio512_address = '0;
        mmio512_writedata = '0;
        mmio512_byteenable = '0;
        ref_wr64_data = '0;
        ref_wr64_addr = '0;
        ref_wr64_mask = '0;
        ref_wr512_data = '0;
        ref_wr512_addr = '0;
        ref_wr512_mask = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // The first identity read lands in the cycle right after reset
        read_once(12'h000);
        read_once(12'h001);
        read_once(12'h002);
        read_once(12'h010);

        // Records read zero before any write
        read_once(12'h020);
        read_once(12'h030);
        read_once(12'h031);
        for (int k = 0; k < 8; k++)
        begin
            read_once(12'h040 + 12'(k));
        end
        read_once(12'h050);
        read_once(12'h051);

        // Narrow record, then a second write that replaces it
        for (int n = 0; n < 2; n++)
        begin
            write_narrow(12'($urandom), {$urandom, $urandom}, 8'($urandom));
            read_once(12'h020);
            read_once(12'h030);
            read_once(12'h031);
        end

        // Wide record with all eight slices
        write_wide(6'($urandom), random_line(), {$urandom, $urandom});
        for (int k = 0; k < 8; k++)
        begin
            read_once(12'h040 + 12'(k));
        end
        read_once(12'h050);
        read_once(12'h051);

        // Unmapped indices next to mapped ones, then random ones above 0x060
        read_once(12'h003);
        read_once(12'h011);
        read_once(12'h032);
        read_once(12'h048);
        read_once(12'h052);
        repeat (10)
        begin
            addr = 12'($urandom_range(12'hfff, 12'h061));
            read_once(addr);
        end

        // Read held high across four requests must return in order
        read_word(12'h000);
        read_word(12'h001);
        read_word(12'h020);
        read_word(12'h050);
        mmio64_read = 1'b0;

        while (exp_q.size() != 0)
        begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* mmio_test_target.f */
hw/mmio_test_pkg.sv
hw/wait_pattern_gen.sv
hw/write_capture.sv
hw/csr_read_mux.sv
hw/mmio_test_target.sv
testbench/tb_mmio_test_target.sv
